//--- common/fdsu_pkg.sv
//====================================================================
// Shared widths, encodings and field bundles of the FDSU controller.
// The iteration counter width limits the round count to 31.
//====================================================================
package fdsu_pkg;

  // Exponent, iteration counter and register index widths
  parameter int EXPNT_W = 10;
  parameter int CNT_W   = 5;
  parameter int FREG_W  = 5;

  typedef logic [EXPNT_W-1:0] expnt_t;
  typedef logic [FREG_W-1:0]  freg_t;

  // IEEE rounding modes, dyn selects the mode from fcsr
  typedef enum logic [2:0] {
    rne = 3'b000,
    rtz = 3'b001,
    rdn = 3'b010,
    rup = 3'b011,
    rmm = 3'b100,
    dyn = 3'b111
  } fdsu_rm_e;

  // Main sequencing states
  typedef enum logic [2:0] {
    idle = 3'd0,
    wfi2 = 3'd1,
    iter = 3'd2,
    rnd  = 3'd3,
    pack = 3'd4,
    wfwb = 3'd5
  } fdsu_state_e;

  // Write-back tracking states
  typedef enum logic [1:0] {
    wb_idle  = 2'b00,
    wb_ex2   = 2'b10,
    wb_cmplt = 2'b01
  } fdsu_wb_state_e;

  // Control fields captured when an instruction leaves EX1
  typedef struct packed {
    freg_t    wb_freg;
    logic     result_sign;
    logic     div;
    logic     sqrt;
    fdsu_rm_e rm;
    logic     of_rm_lfn;
  } fdsu_issue_t;

  // Result flags produced at the end of EX2
  typedef struct packed {
    logic result_inf;
    logic result_lfn;
    logic of;
    logic uf;
    logic potnt_of;
    logic potnt_uf;
  } fdsu_ex2_flags_t;

endpackage

//--- fdsu_ctrl/fdsu_main_fsm.sv
`timescale 1ns/1ps
//====================================================================
// Main sequencer. An instruction leaves EX1 on acceptance, the
// operand preparation cycle (wfi2) follows it when op1_id_vld is set.
//====================================================================
module fdsu_main_fsm #(
  parameter int SRT_ROUNDS = 15
) (
  input  logic fdsu_clk,
  input  logic cpurst_b,
  input  logic ex1_inst_vld,
  input  logic op1_id_vld,
  input  logic srt_remainder_zero,
  input  logic ex2_of,
  input  logic wb_grant,
  input  logic fdsu_flush,
  output logic iter_start,
  output logic ex2_pipedown,
  output logic ex3_pipedown,
  output logic sm_cmplt,
  output logic sm_idle,
  output logic sm_ex1_ready,
  output logic dn_stall,
  output logic ex1_op1_sel,
  output logic srt_sm_on
);
  import fdsu_pkg::*;

  // Round one starts from SRT_ROUNDS-1
  localparam logic [CNT_W-1:0] CNT_INI = CNT_W'(SRT_ROUNDS - 1);

  fdsu_state_e      cur_state;
  fdsu_state_e      next_state;
  fdsu_state_e      start_state;
  logic [CNT_W-1:0] srt_cnt;
  logic             srt_itering;
  logic             last_round;

  //==================================================================
  // State register and next state
  //==================================================================
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= idle;
    else if (fdsu_flush)
      cur_state <= idle;
    else
      cur_state <= next_state;
  end

  assign start_state = op1_id_vld ? wfi2 : iter;

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      idle:
      begin
        if (iter_start)
          next_state = start_state;
      end
      wfi2:
        next_state = iter;
      iter:
      begin
        if (last_round)
          next_state = rnd;
      end
      rnd:
        next_state = pack;
      // Granted result either drains to idle or chains the next one
      pack, wfwb:
      begin
        if (iter_start)
          next_state = start_state;
        else if (wb_grant)
          next_state = idle;
        else
          next_state = wfwb;
      end
      default:
        next_state = idle;
    endcase
  end

  //==================================================================
  // Iteration counter
  //==================================================================
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_cnt <= '0;
    else if (fdsu_flush)
      srt_cnt <= '0;
    else if (iter_start)
      srt_cnt <= CNT_INI;
    else if (srt_itering)
      srt_cnt <= srt_cnt - 1'b1;
  end

  // Count exhausted, exact quotient or overflow ends the loop
  assign last_round = srt_itering && (srt_cnt == '0 || srt_remainder_zero || ex2_of);

  assign srt_itering  = (cur_state == iter);
  assign sm_idle      = (cur_state == idle);
  assign sm_cmplt     = (cur_state == pack) || (cur_state == wfwb);
  assign sm_ex1_ready = sm_idle || (sm_cmplt && wb_grant);
  assign iter_start   = ex1_inst_vld && sm_ex1_ready;
  assign ex2_pipedown = last_round;
  assign ex3_pipedown = (cur_state == rnd);
  assign ex1_op1_sel  = (cur_state == wfi2);
  // EX1 still busy with the second operand
  assign dn_stall     = (cur_state == wfi2);
  assign srt_sm_on    = srt_itering;

  state_legal_a: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    cur_state inside {idle, wfi2, iter, rnd, pack, wfwb});

  // A running count stays within the loaded range
  cnt_no_wrap_a: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    srt_itering |-> (srt_cnt <= CNT_INI));

endmodule

//--- fdsu_ctrl/fdsu_wb_fsm.sv
`timescale 1ns/1ps
//====================================================================
// Write-back tracking, EX1 stall and flush decision. A start while
// the pipeline holds EX1 is squashed by an internal flush.
//====================================================================
module fdsu_wb_fsm (
  input  logic fdsu_clk,
  input  logic cpurst_b,
  input  logic ex1_inst_vld,
  input  logic ex1_stall_in,
  input  logic iter_start,
  input  logic dn_stall,
  input  logic sm_cmplt,
  input  logic sm_idle,
  input  logic sm_ex1_ready,
  input  logic wb_grant,
  input  logic ex1_cancel,
  input  logic ex2_cancel,
  input  logic async_flush,
  output logic wb_vld,
  output logic fdsu_ex1_stall,
  output logic fdsu_flush,
  output logic no_op
);
  import fdsu_pkg::*;

  fdsu_wb_state_e wb_cur_state;
  fdsu_wb_state_e wb_nxt_state;
  logic           wb_done;
  logic           ex1_window;
  logic           start_squash;

  //==================================================================
  // Write-back state machine
  //==================================================================
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_cur_state <= wb_idle;
    else if (fdsu_flush)
      wb_cur_state <= wb_idle;
    else
      wb_cur_state <= wb_nxt_state;
  end

  always_comb
  begin
    wb_nxt_state = wb_cur_state;
    case (wb_cur_state)
      wb_idle:
      begin
        if (iter_start)
          wb_nxt_state = wb_ex2;
      end
      // One cycle in EX2, then wait for the result
      wb_ex2:
        wb_nxt_state = wb_cmplt;
      wb_cmplt:
      begin
        if (wb_done)
          wb_nxt_state = iter_start ? wb_ex2 : wb_idle;
      end
      default:
        wb_nxt_state = wb_idle;
    endcase
  end

  assign wb_vld  = sm_cmplt && (wb_cur_state != wb_idle);
  assign wb_done = wb_vld && wb_grant;

  //==================================================================
  // Stall and flush
  //==================================================================
  assign fdsu_ex1_stall = ex1_inst_vld && (!sm_ex1_ready || ex1_stall_in);

  // Instruction still owned by EX1
  assign ex1_window   = (wb_cur_state == wb_idle)
                     || (wb_cur_state == wb_cmplt && wb_done)
                     || dn_stall;
  assign start_squash = iter_start && ex1_stall_in;

  assign fdsu_flush = ex1_cancel && ex1_window
                   || ex2_cancel && (wb_cur_state == wb_ex2)
                   || start_squash
                   || async_flush;

  assign no_op = sm_idle && (wb_cur_state == wb_idle) && !ex1_inst_vld;

  // A finished result must always have a write-back slot tracked
  cmplt_tracked_a: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    sm_cmplt |-> (wb_cur_state != wb_idle));

  // Offered result is held until the bus takes it
  wb_hold_a: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    (wb_vld && !wb_grant && !fdsu_flush) |=> wb_vld);

endmodule

//--- verilog/fdsu_stage_regs.sv
`timescale 1ns/1ps
//====================================================================
// EX1 control, EX2 flag and exponent result registers. Contents are
// only meaningful while a result is offered for write-back.
//====================================================================
module fdsu_stage_regs (
  input  logic                      fdsu_clk,
  input  logic                      iter_start,
  input  logic                      ex2_pipedown,
  input  logic                      ex3_pipedown,
  input  fdsu_pkg::fdsu_issue_t     issue,
  input  fdsu_pkg::fdsu_ex2_flags_t ex2_flags,
  input  fdsu_pkg::expnt_t          ex1_expnt,
  input  fdsu_pkg::expnt_t          ex2_srt_expnt,
  input  fdsu_pkg::expnt_t          ex3_expnt_adjust,
  output fdsu_pkg::fdsu_issue_t     result,
  output fdsu_pkg::fdsu_ex2_flags_t result_flags,
  output fdsu_pkg::expnt_t          expnt_rst
);

  //==================================================================
  // EX1 control fields
  //==================================================================
  always_ff @(posedge fdsu_clk)
  begin
    if (iter_start)
      result <= issue;
  end

  //==================================================================
  // EX2 result flags
  //==================================================================
  always_ff @(posedge fdsu_clk)
  begin
    if (ex2_pipedown)
      result_flags <= ex2_flags;
  end

  //==================================================================
  // Shared exponent register
  //==================================================================
  // Holds the operand exponent, then the SRT exponent, then the
  // adjusted result exponent as the instruction moves on
  always_ff @(posedge fdsu_clk)
  begin
    if (iter_start)
      expnt_rst <= ex1_expnt;
    else if (ex2_pipedown)
      expnt_rst <= ex2_srt_expnt;
    else if (ex3_pipedown)
      expnt_rst <= ex3_expnt_adjust;
  end

endmodule

//--- verilog/fdsu_ctrl_top.sv
`timescale 1ns/1ps
//====================================================================
// FDSU sequencing controller. SRT_ROUNDS is 15 for single precision
// and 29 for double, and must stay below 32.
//====================================================================
module fdsu_ctrl_top #(
  parameter int SRT_ROUNDS = 15
) (
  input  logic                     fdsu_clk,
  input  logic                     cpurst_b,
  // EX1 issue
  input  logic                     ex1_inst_vld,
  input  fdsu_pkg::fdsu_issue_t    issue,
  input  logic                     op1_id_vld,
  input  logic                     ex1_stall_in,
  // Pipeline flush
  input  logic                     ex1_cancel,
  input  logic                     ex2_cancel,
  input  logic                     async_flush,
  // Datapath status
  input  logic                     srt_remainder_zero,
  input  fdsu_pkg::fdsu_ex2_flags_t ex2_flags,
  input  fdsu_pkg::expnt_t         ex1_expnt,
  input  fdsu_pkg::expnt_t         ex2_srt_expnt,
  input  fdsu_pkg::expnt_t         ex3_expnt_adjust,
  // Register file write-back
  input  logic                     wb_grant,
  output logic                     wb_vld,
  output fdsu_pkg::fdsu_issue_t    result,
  output fdsu_pkg::fdsu_ex2_flags_t result_flags,
  output fdsu_pkg::expnt_t         expnt_rst,
  // Status and strobes to the datapath
  output logic                     fdsu_ex1_stall,
  output logic                     no_op,
  output logic                     srt_sm_on,
  output logic                     ex1_op1_sel,
  output logic                     ex1_pipedown,
  output logic                     ex2_pipedown,
  output logic                     ex3_pipedown
);

  logic sm_cmplt;
  logic sm_idle;
  logic sm_ex1_ready;
  logic dn_stall;
  logic fdsu_flush;

  fdsu_main_fsm #(
    .SRT_ROUNDS (SRT_ROUNDS)
  ) i_fdsu_main_fsm (
    .fdsu_clk           (fdsu_clk),
    .cpurst_b           (cpurst_b),
    .ex1_inst_vld       (ex1_inst_vld),
    .op1_id_vld         (op1_id_vld),
    .srt_remainder_zero (srt_remainder_zero),
    .ex2_of             (ex2_flags.of),
    .wb_grant           (wb_grant),
    .fdsu_flush         (fdsu_flush),
    .iter_start         (ex1_pipedown),
    .ex2_pipedown       (ex2_pipedown),
    .ex3_pipedown       (ex3_pipedown),
    .sm_cmplt           (sm_cmplt),
    .sm_idle            (sm_idle),
    .sm_ex1_ready       (sm_ex1_ready),
    .dn_stall           (dn_stall),
    .ex1_op1_sel        (ex1_op1_sel),
    .srt_sm_on          (srt_sm_on)
  );

  fdsu_wb_fsm i_fdsu_wb_fsm (
    .fdsu_clk       (fdsu_clk),
    .cpurst_b       (cpurst_b),
    .ex1_inst_vld   (ex1_inst_vld),
    .ex1_stall_in   (ex1_stall_in),
    .iter_start     (ex1_pipedown),
    .dn_stall       (dn_stall),
    .sm_cmplt       (sm_cmplt),
    .sm_idle        (sm_idle),
    .sm_ex1_ready   (sm_ex1_ready),
    .wb_grant       (wb_grant),
    .ex1_cancel     (ex1_cancel),
    .ex2_cancel     (ex2_cancel),
    .async_flush    (async_flush),
    .wb_vld         (wb_vld),
    .fdsu_ex1_stall (fdsu_ex1_stall),
    .fdsu_flush     (fdsu_flush),
    .no_op          (no_op)
  );

  fdsu_stage_regs i_fdsu_stage_regs (
    .fdsu_clk         (fdsu_clk),
    .iter_start       (ex1_pipedown),
    .ex2_pipedown     (ex2_pipedown),
    .ex3_pipedown     (ex3_pipedown),
    .issue            (issue),
    .ex2_flags        (ex2_flags),
    .ex1_expnt        (ex1_expnt),
    .ex2_srt_expnt    (ex2_srt_expnt),
    .ex3_expnt_adjust (ex3_expnt_adjust),
    .result           (result),
    .result_flags     (result_flags),
    .expnt_rst        (expnt_rst)
  );

endmodule

//--- tests/fdsu_tb_tasks.svh
//====================================================================
// Issue, wait, compare and directed test tasks of the FDSU testbench.
// The overflow flag stays low so that only the remainder ends early.
//====================================================================

//====================================================================
// Random stimulus
//====================================================================
function automatic fdsu_issue_t rand_issue();
  fdsu_issue_t iss;
  iss    = fdsu_issue_t'(12'($urandom));
  iss.rm = fdsu_rm_e'(3'($urandom_range(4, 0)));
  return iss;
endfunction

function automatic fdsu_ex2_flags_t rand_flags();
  fdsu_ex2_flags_t flags;
  flags    = fdsu_ex2_flags_t'(6'($urandom));
  flags.of = 1'b0;
  return flags;
endfunction

//====================================================================
// Compare tasks
//====================================================================
task automatic compare_issue(input string what, input fdsu_issue_t exp, input fdsu_issue_t act);
  if (act !== exp)
  begin
    $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
    errors++;
  end
endtask

task automatic compare_flags(input string what, input fdsu_ex2_flags_t exp,
                             input fdsu_ex2_flags_t act);
  if (act !== exp)
  begin
    $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
    errors++;
  end
endtask

task automatic compare_expnt(input string what, input expnt_t exp, input expnt_t act);
  if (act !== exp)
  begin
    $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
    errors++;
  end
endtask

task automatic compare_bit(input string what, input logic exp, input logic act);
  if (act !== exp)
  begin
    $display("ERR %s %s: expected %b actual %b", cur_test, what, exp, act);
    errors++;
  end
endtask

task automatic compare_count(input string what, input int exp, input int act);
  if (act != exp)
  begin
    $display("ERR %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    errors++;
  end
endtask

//====================================================================
// Test framing
//====================================================================
task automatic begin_test(input string name);
  cur_test    = name;
  test_errors = errors;
endtask

task automatic end_test();
  tests_run++;
  if (errors == test_errors)
    $display("%-20s ok", cur_test);
  else
  begin
    tests_failed++;
    $display("%-20s FAILED with %0d errors", cur_test, errors - test_errors);
  end
endtask

//====================================================================
// Issue, wait and drain
//====================================================================
// Outputs of an idle unit right after reset
task automatic check_reset_values();
  @(negedge fdsu_clk);
  compare_bit("wb_vld after reset", 1'b0, wb_vld);
  compare_bit("fdsu_ex1_stall after reset", 1'b0, fdsu_ex1_stall);
  compare_bit("srt_sm_on after reset", 1'b0, srt_sm_on);
  compare_bit("ex1_op1_sel after reset", 1'b0, ex1_op1_sel);
  compare_bit("ex1_pipedown after reset", 1'b0, ex1_pipedown);
  compare_bit("ex2_pipedown after reset", 1'b0, ex2_pipedown);
  compare_bit("ex3_pipedown after reset", 1'b0, ex3_pipedown);
  compare_bit("no_op after reset", 1'b1, no_op);
endtask

// Drives new operands at a rising edge and records the expected result
task automatic set_operands(input logic with_op1);
  cur_issue  = rand_issue();
  cur_flags  = rand_flags();
  cur_adjust = EXPNT_W'($urandom);
  issue            <= cur_issue;
  ex2_flags        <= cur_flags;
  ex1_expnt        <= EXPNT_W'($urandom);
  ex2_srt_expnt    <= EXPNT_W'($urandom);
  ex3_expnt_adjust <= cur_adjust;
  op1_id_vld       <= with_op1;
  ex1_inst_vld     <= 1'b1;
endtask

// Returns at the accept edge
task automatic issue_inst(input logic with_op1);
  int wait_cnt;
  @(posedge fdsu_clk);
  set_operands(with_op1);
  wait_cnt = 0;
  @(negedge fdsu_clk);
  while (fdsu_ex1_stall && wait_cnt < ISSUE_TIMEOUT)
  begin
    @(negedge fdsu_clk);
    wait_cnt++;
  end
  if (fdsu_ex1_stall)
  begin
    $display("%s: instruction was never accepted, stall stayed high", cur_test);
    errors++;
  end
  else
    compare_bit("ex1_pipedown at accept", 1'b1, ex1_pipedown);
  @(posedge fdsu_clk);
  ex1_inst_vld <= 1'b0;
  op1_id_vld   <= 1'b0;
endtask

// Counts cycles from the accept edge until wb_vld, with the zero
// remainder raised in round rz_round when it is above zero
// EX2 pipedown marks the last round and EX3 pipedown the round cycle
task automatic wait_result(input int rz_round, output int cycles, output int op1_cnt,
                           output int late_on);
  int   n;
  int   ex2_cnt;
  int   ex2_at;
  int   ex3_cnt;
  int   ex3_at;
  logic seen;
  n       = 0;
  ex2_cnt = 0;
  ex2_at  = 0;
  ex3_cnt = 0;
  ex3_at  = 0;
  seen    = 1'b0;
  op1_cnt = 0;
  late_on = 0;
  while (!seen && n < WB_TIMEOUT)
  begin
    n++;
    srt_remainder_zero <= (n == rz_round);
    @(negedge fdsu_clk);
    if (ex1_op1_sel)
      op1_cnt++;
    if (rz_round > 0 && n > rz_round && srt_sm_on)
      late_on++;
    if (ex2_pipedown)
    begin
      ex2_cnt++;
      ex2_at = n;
    end
    if (ex3_pipedown)
    begin
      ex3_cnt++;
      ex3_at = n;
    end
    seen = wb_vld;
    if (!seen)
      @(posedge fdsu_clk);
  end
  if (!seen)
  begin
    $display("%s: wb_vld never rose within %0d cycles", cur_test, WB_TIMEOUT);
    errors++;
  end
  else
  begin
    compare_count("ex2_pipedown pulses", 1, ex2_cnt);
    compare_count("ex2_pipedown cycle", n - 2, ex2_at);
    compare_count("ex3_pipedown pulses", 1, ex3_cnt);
    compare_count("ex3_pipedown cycle", n - 1, ex3_at);
  end
  cycles = n;
endtask

task automatic check_result();
  compare_issue("result", cur_issue, result);
  compare_flags("result_flags", cur_flags, result_flags);
  compare_expnt("expnt_rst", cur_adjust, expnt_rst);
endtask

// One-cycle grant that must retire the result
task automatic drain_result();
  @(posedge fdsu_clk);
  wb_grant <= 1'b1;
  @(posedge fdsu_clk);
  wb_grant <= 1'b0;
  @(negedge fdsu_clk);
  compare_bit("wb_vld after grant", 1'b0, wb_vld);
endtask

//====================================================================
// Directed tests
//====================================================================
task automatic basic_divide_test();
  int cycles;
  int op1_cnt;
  int late_on;
  begin_test("basic_divide");
  check_reset_values();
  issue_inst(1'b0);
  wait_result(0, cycles, op1_cnt, late_on);
  compare_count("latency", SRT_ROUNDS + 2, cycles);
  check_result();
  drain_result();
  end_test();
endtask

task automatic op_prep_test();
  int cycles;
  int op1_cnt;
  int late_on;
  begin_test("operand_prep");
  issue_inst(1'b1);
  wait_result(0, cycles, op1_cnt, late_on);
  compare_count("latency", SRT_ROUNDS + 3, cycles);
  compare_count("ex1_op1_sel cycles", 1, op1_cnt);
  check_result();
  drain_result();
  end_test();
endtask

task automatic early_exit_test();
  int cycles;
  int op1_cnt;
  int late_on;
  int k;
  begin_test("early_exit");
  k = $urandom_range(10, 1);
  issue_inst(1'b0);
  wait_result(k, cycles, op1_cnt, late_on);
  compare_count("latency", k + 2, cycles);
  compare_count("srt_sm_on cycles after exit", 0, late_on);
  check_result();
  drain_result();
  compare_bit("srt_sm_on after drain", 1'b0, srt_sm_on);
  end_test();
endtask

task automatic back_pressure_test();
  int              cycles;
  int              op1_cnt;
  int              late_on;
  int              hold;
  int              i;
  fdsu_issue_t     first_issue;
  fdsu_ex2_flags_t first_flags;
  expnt_t          first_adjust;
  begin_test("back_pressure");
  issue_inst(1'b0);
  wait_result(0, cycles, op1_cnt, late_on);
  compare_count("first latency", SRT_ROUNDS + 2, cycles);
  check_result();
  first_issue  = cur_issue;
  first_flags  = cur_flags;
  first_adjust = cur_adjust;
  hold = $urandom_range(8, 3);
  // Second instruction waits behind the ungranted result
  @(posedge fdsu_clk);
  set_operands(1'b0);
  for (i = 0; i < hold; i++)
  begin
    @(negedge fdsu_clk);
    compare_bit("wb_vld held", 1'b1, wb_vld);
    compare_bit("fdsu_ex1_stall", 1'b1, fdsu_ex1_stall);
    compare_bit("ex1_pipedown while stalled", 1'b0, ex1_pipedown);
    compare_issue("held result", first_issue, result);
    compare_flags("held result_flags", first_flags, result_flags);
    compare_expnt("held expnt_rst", first_adjust, expnt_rst);
    @(posedge fdsu_clk);
  end
  wb_grant <= 1'b1;
  @(negedge fdsu_clk);
  compare_bit("fdsu_ex1_stall with grant", 1'b0, fdsu_ex1_stall);
  compare_bit("ex1_pipedown with grant", 1'b1, ex1_pipedown);
  // Transfer of the first and accept of the second on one edge
  @(posedge fdsu_clk);
  wb_grant     <= 1'b0;
  ex1_inst_vld <= 1'b0;
  wait_result(0, cycles, op1_cnt, late_on);
  compare_count("chained latency", SRT_ROUNDS + 2, cycles);
  check_result();
  drain_result();
  end_test();
endtask

task automatic flush_test();
  int cycles;
  int op1_cnt;
  int late_on;
  int m;
  int n;
  int vld_cnt;
  begin_test("flush");
  m       = $urandom_range(10, 2);
  vld_cnt = 0;
  issue_inst(1'b0);
  for (n = 1; n <= SRT_ROUNDS + 5; n++)
  begin
    async_flush <= (n == m);
    @(negedge fdsu_clk);
    if (wb_vld)
      vld_cnt++;
    @(posedge fdsu_clk);
  end
  async_flush <= 1'b0;
  @(negedge fdsu_clk);
  compare_count("wb_vld cycles after flush", 0, vld_cnt);
  compare_bit("no_op after flush", 1'b1, no_op);
  issue_inst(1'b0);
  wait_result(0, cycles, op1_cnt, late_on);
  compare_count("latency after flush", SRT_ROUNDS + 2, cycles);
  check_result();
  drain_result();
  end_test();
endtask

//--- tests/fdsu_ctrl_tb.sv
`timescale 1ns/1ps
//====================================================================
// Directed testbench of the FDSU controller, SRT_ROUNDS at 15.
// Inputs change on the rising edge, outputs are sampled at negedge.
//====================================================================
module fdsu_ctrl_tb;
  import fdsu_pkg::*;

  localparam int SRT_ROUNDS    = 15;
  localparam int ISSUE_TIMEOUT = 20;
  localparam int WB_TIMEOUT    = SRT_ROUNDS + 20;

  // DUT inputs
  logic            fdsu_clk;
  logic            cpurst_b;
  logic            ex1_inst_vld;
  fdsu_issue_t     issue;
  logic            op1_id_vld;
  logic            ex1_stall_in;
  logic            ex1_cancel;
  logic            ex2_cancel;
  logic            async_flush;
  logic            srt_remainder_zero;
  fdsu_ex2_flags_t ex2_flags;
  expnt_t          ex1_expnt;
  expnt_t          ex2_srt_expnt;
  expnt_t          ex3_expnt_adjust;
  logic            wb_grant;

  // DUT outputs
  logic            wb_vld;
  fdsu_issue_t     result;
  fdsu_ex2_flags_t result_flags;
  expnt_t          expnt_rst;
  logic            fdsu_ex1_stall;
  logic            no_op;
  logic            srt_sm_on;
  logic            ex1_op1_sel;
  logic            ex1_pipedown;
  logic            ex2_pipedown;
  logic            ex3_pipedown;

  // Expected result of the instruction last issued
  fdsu_issue_t     cur_issue;
  fdsu_ex2_flags_t cur_flags;
  expnt_t          cur_adjust;

  // Test bookkeeping
  string           cur_test;
  int              errors;
  int              test_errors;
  int              tests_run;
  int              tests_failed;

  fdsu_ctrl_top #(
    .SRT_ROUNDS (SRT_ROUNDS)
  ) i_fdsu_ctrl_top (
    .fdsu_clk           (fdsu_clk),
    .cpurst_b           (cpurst_b),
    .ex1_inst_vld       (ex1_inst_vld),
    .issue              (issue),
    .op1_id_vld         (op1_id_vld),
    .ex1_stall_in       (ex1_stall_in),
    .ex1_cancel         (ex1_cancel),
    .ex2_cancel         (ex2_cancel),
    .async_flush        (async_flush),
    .srt_remainder_zero (srt_remainder_zero),
    .ex2_flags          (ex2_flags),
    .ex1_expnt          (ex1_expnt),
    .ex2_srt_expnt      (ex2_srt_expnt),
    .ex3_expnt_adjust   (ex3_expnt_adjust),
    .wb_grant           (wb_grant),
    .wb_vld             (wb_vld),
    .result             (result),
    .result_flags       (result_flags),
    .expnt_rst          (expnt_rst),
    .fdsu_ex1_stall     (fdsu_ex1_stall),
    .no_op              (no_op),
    .srt_sm_on          (srt_sm_on),
    .ex1_op1_sel        (ex1_op1_sel),
    .ex1_pipedown       (ex1_pipedown),
    .ex2_pipedown       (ex2_pipedown),
    .ex3_pipedown       (ex3_pipedown)
  );

  `include "fdsu_tb_tasks.svh"

  // 10 ns clock
  always #5 fdsu_clk = ~fdsu_clk;

  //==================================================================
  // Test sequence
  //==================================================================
  initial
  begin
    void'($urandom(32'h0570d88b));
    fdsu_clk           = 1'b0;
    cpurst_b           = 1'b0;
    ex1_inst_vld       = 1'b0;
    issue              = '0;
    op1_id_vld         = 1'b0;
    ex1_stall_in       = 1'b0;
    ex1_cancel         = 1'b0;
    ex2_cancel         = 1'b0;
    async_flush        = 1'b0;
    srt_remainder_zero = 1'b0;
    ex2_flags          = '0;
    ex1_expnt          = '0;
    ex2_srt_expnt      = '0;
    ex3_expnt_adjust   = '0;
    wb_grant           = 1'b0;
    errors             = 0;
    tests_run          = 0;
    tests_failed       = 0;
    repeat (5) @(posedge fdsu_clk);
    cpurst_b <= 1'b1;
    @(posedge fdsu_clk);
    basic_divide_test();
    op_prep_test();
    early_exit_test();
    back_pressure_test();
    flush_test();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- sim.f
+incdir+tests
common/fdsu_pkg.sv
fdsu_ctrl/fdsu_main_fsm.sv
fdsu_ctrl/fdsu_wb_fsm.sv
verilog/fdsu_stage_regs.sv
verilog/fdsu_ctrl_top.sv
tests/fdsu_ctrl_tb.sv
